// File: design/vec_pkg.sv
// Sizes are fixed here; NrLanes must stay a power of two and all sums wrap at ElemWidth bits
`default_nettype none

package vec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Parallel lanes, power of two
  localparam int unsigned NrLanes   = 4;
  // Bits per vector element
  localparam int unsigned ElemWidth = 16;
  // Vector registers held in every lane
  localparam int unsigned NrVRegs   = 8;
  // Reduction result, wraps modulo 2**ElemWidth
  localparam int unsigned SumWidth  = ElemWidth;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ElemWidth-1:0]        elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;
  typedef logic [$clog2(NrLanes)-1:0] lane_idx_t;

  // Host instruction set
  typedef enum logic [2:0] {
    OP_VADD    = 3'd0,  // vd = vs1 + vs2
    OP_VXOR    = 3'd1,  // vd = vs1 ^ vs2
    OP_VIOTA   = 3'd2,  // vd = scalar + lane index
    OP_VBCAST  = 3'd3,  // vd = scalar, lane by lane
    OP_VREDSUM = 3'd4,  // result = sum of vs1
    OP_VEXT    = 3'd5   // result = vs1 of one lane
  } opcode_e;

  // Sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0,
    SEQ_BCAST  = 2'd1,
    SEQ_REDUCE = 2'd2
  } seq_state_e;

  // What the reducer returns
  typedef enum logic {
    RED_SUM = 1'b0,
    RED_EXT = 1'b1
  } red_op_e;

endpackage : vec_pkg

`default_nettype wire

// File: design/vec_sequencer.sv
// No back-pressure: requests while busy_o is high or right after another request are dropped
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Host request
  input  logic                req_valid_i,
  input  vec_pkg::opcode_e    req_op_i,
  input  vec_pkg::vreg_idx_t  req_vd_i,
  input  vec_pkg::vreg_idx_t  req_vs1_i,
  input  vec_pkg::vreg_idx_t  req_vs2_i,
  input  vec_pkg::elem_t      req_scalar_i,
  input  vec_pkg::lane_idx_t  req_lane_i,
  output logic                busy_o,
  // To all lanes
  output logic                op_valid_o,
  output vec_pkg::opcode_e    op_o,
  output vec_pkg::vreg_idx_t  vd_o,
  output vec_pkg::vreg_idx_t  vs1_o,
  output vec_pkg::vreg_idx_t  vs2_o,
  output vec_pkg::elem_t      scalar_o,
  // Head of the broadcast chain
  output logic                bc_valid_o,
  output vec_pkg::elem_t      bc_data_o,
  // To the reducer
  output logic                red_start_o,
  output vec_pkg::red_op_e    red_op_o,
  output vec_pkg::lane_idx_t  red_lane_o
);

  vec_pkg::seq_state_e state_q, state_d;
  vec_pkg::lane_idx_t  cnt_q, cnt_d;
  logic                req_prev_q;
  logic                accept;
  logic                is_lane_op;
  logic                is_red_op;
  logic                is_bcast;

  logic                op_valid_q;
  logic                bc_valid_q;
  logic                red_start_q;
  vec_pkg::opcode_e    op_q;
  vec_pkg::vreg_idx_t  vd_q, vs1_q, vs2_q;
  vec_pkg::elem_t      scalar_q;
  vec_pkg::red_op_e    red_op_q;
  vec_pkg::lane_idx_t  red_lane_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////////////////////

  assign accept     = req_valid_i && (state_q == vec_pkg::SEQ_IDLE) && !req_prev_q;
  assign is_lane_op = req_op_i inside {vec_pkg::OP_VADD, vec_pkg::OP_VXOR, vec_pkg::OP_VIOTA};
  assign is_red_op  = req_op_i inside {vec_pkg::OP_VREDSUM, vec_pkg::OP_VEXT};
  assign is_bcast   = (req_op_i == vec_pkg::OP_VBCAST);

  // Counter holds remaining busy cycles minus one
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      vec_pkg::SEQ_IDLE: begin
        if (accept && is_bcast) begin
          state_d = vec_pkg::SEQ_BCAST;
          cnt_d   = vec_pkg::lane_idx_t'(vec_pkg::NrLanes - 1);
        end else if (accept && is_red_op) begin
          state_d = vec_pkg::SEQ_REDUCE;
          cnt_d   = vec_pkg::lane_idx_t'(1);
        end
      end
      vec_pkg::SEQ_BCAST, vec_pkg::SEQ_REDUCE: begin
        if (cnt_q == '0) begin
          state_d = vec_pkg::SEQ_IDLE;
        end else begin
          cnt_d = cnt_q - vec_pkg::lane_idx_t'(1);
        end
      end
      default: state_d = vec_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= vec_pkg::SEQ_IDLE;
      cnt_q       <= '0;
      req_prev_q  <= 1'b0;
      op_valid_q  <= 1'b0;
      bc_valid_q  <= 1'b0;
      red_start_q <= 1'b0;
      op_q        <= vec_pkg::OP_VADD;
      vd_q        <= '0;
      vs1_q       <= '0;
      vs2_q       <= '0;
      scalar_q    <= '0;
      red_op_q    <= vec_pkg::RED_SUM;
      red_lane_q  <= '0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      req_prev_q  <= req_valid_i;
      op_valid_q  <= accept && is_lane_op;
      bc_valid_q  <= accept && is_bcast;
      red_start_q <= accept && is_red_op;
      // vd stays put until the next accepted request, so the chain sees it
      if (accept) begin
        op_q       <= req_op_i;
        vd_q       <= req_vd_i;
        vs1_q      <= req_vs1_i;
        vs2_q      <= req_vs2_i;
        scalar_q   <= req_scalar_i;
        red_lane_q <= req_lane_i;
        red_op_q   <= (req_op_i == vec_pkg::OP_VEXT) ? vec_pkg::RED_EXT : vec_pkg::RED_SUM;
      end
    end
  end

  assign busy_o      = (state_q != vec_pkg::SEQ_IDLE);
  assign op_valid_o  = op_valid_q;
  assign op_o        = op_q;
  assign vd_o        = vd_q;
  assign vs1_o       = vs1_q;
  assign vs2_o       = vs2_q;
  assign scalar_o    = scalar_q;
  assign bc_valid_o  = bc_valid_q;
  assign bc_data_o   = scalar_q;
  assign red_start_o = red_start_q;
  assign red_op_o    = red_op_q;
  assign red_lane_o  = red_lane_q;

endmodule : vec_sequencer

`default_nettype wire

// File: design/vec_lane.sv
// Lane ops and broadcast writes share one write port; the sequencer never issues both at once
`timescale 1ns/1ps
`default_nettype none

module vec_lane #(
  parameter vec_pkg::lane_idx_t LaneIdx = '0
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // From the sequencer
  input  logic                op_valid_i,
  input  vec_pkg::opcode_e    op_i,
  input  vec_pkg::vreg_idx_t  vd_i,
  input  vec_pkg::vreg_idx_t  vs1_i,
  input  vec_pkg::vreg_idx_t  vs2_i,
  input  vec_pkg::elem_t      scalar_i,
  // Broadcast chain, previous lane in and next lane out
  input  logic                bc_valid_i,
  input  vec_pkg::elem_t      bc_data_i,
  output logic                bc_valid_o,
  output vec_pkg::elem_t      bc_data_o,
  // Element vs1 for the reducer
  output vec_pkg::elem_t      rd_data_o
);

  vec_pkg::elem_t rf_q [vec_pkg::NrVRegs];
  vec_pkg::elem_t src_a;
  vec_pkg::elem_t src_b;
  vec_pkg::elem_t alu_res;
  logic           bc_valid_q;
  vec_pkg::elem_t bc_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Operand read and ALU
  ////////////////////////////////////////////////////////////////////////////

  assign src_a = rf_q[vs1_i];
  assign src_b = rf_q[vs2_i];

  always_comb begin
    case (op_i)
      vec_pkg::OP_VADD:  alu_res = src_a + src_b;
      vec_pkg::OP_VXOR:  alu_res = src_a ^ src_b;
      // Lane index zero extended onto the scalar
      vec_pkg::OP_VIOTA: alu_res = scalar_i + vec_pkg::elem_t'(LaneIdx);
      default:           alu_res = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file slice
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
        rf_q[r] <= '0;
      end
    end else if (op_valid_i) begin
      rf_q[vd_i] <= alu_res;
    end else if (bc_valid_i) begin
      rf_q[vd_i] <= bc_data_i;
    end
  end

  assign rd_data_o = src_a;

  ////////////////////////////////////////////////////////////////////////////
  // Broadcast stage
  ////////////////////////////////////////////////////////////////////////////

  // One register per lane, so lane k sees the value k cycles after lane 0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bc_valid_q <= 1'b0;
      bc_data_q  <= '0;
    end else begin
      bc_valid_q <= bc_valid_i;
      bc_data_q  <= bc_data_i;
    end
  end

  assign bc_valid_o = bc_valid_q;
  assign bc_data_o  = bc_data_q;

endmodule : vec_lane

`default_nettype wire

// File: design/vec_reducer.sv
// Adder tree assumes NrLanes is a power of two; the sum wraps at SumWidth bits
`timescale 1ns/1ps
`default_nettype none

module vec_reducer (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  // From the sequencer
  input  logic                                      red_start_i,
  input  vec_pkg::red_op_e                          red_op_i,
  input  vec_pkg::lane_idx_t                        red_lane_i,
  // Element vs1 of every lane
  input  vec_pkg::elem_t [vec_pkg::NrLanes-1:0]     lane_data_i,
  // Scalar response to the host
  output logic                                      resp_valid_o,
  output vec_pkg::elem_t                            resp_data_o
);

  // Heap layout: node 0 is the root, leaves start at NrLanes-1
  logic [vec_pkg::SumWidth-1:0] node [2*vec_pkg::NrLanes-1];
  vec_pkg::elem_t               ext_data;
  vec_pkg::elem_t               result;
  logic                         resp_valid_q;
  vec_pkg::elem_t               resp_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Adder tree
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < vec_pkg::NrLanes; l++) begin : gen_leaf
    assign node[vec_pkg::NrLanes-1+l] = lane_data_i[l];
  end : gen_leaf

  // Carry out of each adder is dropped
  for (genvar n = 0; n < vec_pkg::NrLanes - 1; n++) begin : gen_node
    assign node[n] = node[2*n+1] + node[2*n+2];
  end : gen_node

  // Single lane pick for extract
  assign ext_data = lane_data_i[red_lane_i];

  assign result = (red_op_i == vec_pkg::RED_EXT) ? ext_data : node[0];

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
      resp_data_q  <= '0;
    end else begin
      resp_valid_q <= red_start_i;
      if (red_start_i) begin
        resp_data_q <= result;
      end
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;

endmodule : vec_reducer

`default_nettype wire

// File: design/vec_top.sv
// Host must keep req_valid_i low while busy_o is high and for a cycle after each request
`timescale 1ns/1ps
`default_nettype none

module vec_top (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Host request, single-cycle strobe
  input  logic                req_valid_i,
  input  vec_pkg::opcode_e    req_op_i,
  input  vec_pkg::vreg_idx_t  req_vd_i,
  input  vec_pkg::vreg_idx_t  req_vs1_i,
  input  vec_pkg::vreg_idx_t  req_vs2_i,
  input  vec_pkg::elem_t      req_scalar_i,
  input  vec_pkg::lane_idx_t  req_lane_i,
  // Host status and response
  output logic                busy_o,
  output logic                resp_valid_o,
  output vec_pkg::elem_t      resp_data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////////////

  logic                                  op_valid;
  vec_pkg::opcode_e                      op;
  vec_pkg::vreg_idx_t                    vd, vs1, vs2;
  vec_pkg::elem_t                        scalar;
  logic                                  bc_valid;
  vec_pkg::elem_t                        bc_data;
  logic                                  red_start;
  vec_pkg::red_op_e                      red_op;
  vec_pkg::lane_idx_t                    red_lane;

  vec_sequencer i_sequencer (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .req_valid_i (req_valid_i ),
    .req_op_i    (req_op_i    ),
    .req_vd_i    (req_vd_i    ),
    .req_vs1_i   (req_vs1_i   ),
    .req_vs2_i   (req_vs2_i   ),
    .req_scalar_i(req_scalar_i),
    .req_lane_i  (req_lane_i  ),
    .busy_o      (busy_o      ),
    .op_valid_o  (op_valid    ),
    .op_o        (op          ),
    .vd_o        (vd          ),
    .vs1_o       (vs1         ),
    .vs2_o       (vs2         ),
    .scalar_o    (scalar      ),
    .bc_valid_o  (bc_valid    ),
    .bc_data_o   (bc_data     ),
    .red_start_o (red_start   ),
    .red_op_o    (red_op      ),
    .red_lane_o  (red_lane    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Lanes and broadcast chain
  ////////////////////////////////////////////////////////////////////////////

  vec_pkg::elem_t [vec_pkg::NrLanes-1:0] lane_rd_data;
  vec_pkg::elem_t [vec_pkg::NrLanes-1:0] bc_lane_data_in;
  vec_pkg::elem_t [vec_pkg::NrLanes-1:0] bc_lane_data_out;
  logic           [vec_pkg::NrLanes-1:0] bc_lane_valid_in;
  logic           [vec_pkg::NrLanes-1:0] bc_lane_valid_out;

  for (genvar lane = 0; lane < vec_pkg::NrLanes; lane++) begin : gen_lanes
    vec_lane #(
      .LaneIdx(vec_pkg::lane_idx_t'(lane))
    ) i_lane (
      .clk_i     (clk_i                  ),
      .arst_n_i  (arst_n_i               ),
      .op_valid_i(op_valid               ),
      .op_i      (op                     ),
      .vd_i      (vd                     ),
      .vs1_i     (vs1                    ),
      .vs2_i     (vs2                    ),
      .scalar_i  (scalar                 ),
      .bc_valid_i(bc_lane_valid_in[lane] ),
      .bc_data_i (bc_lane_data_in[lane]  ),
      .bc_valid_o(bc_lane_valid_out[lane]),
      .bc_data_o (bc_lane_data_out[lane] ),
      .rd_data_o (lane_rd_data[lane]     )
    );

    // Lane 0 takes the sequencer, the rest take their left neighbour
    if (lane == 0) begin : gen_bc_first
      assign bc_lane_valid_in[0] = bc_valid;
      assign bc_lane_data_in[0]  = bc_data;
    end else begin : gen_bc_next
      assign bc_lane_valid_in[lane] = bc_lane_valid_out[lane-1];
      assign bc_lane_data_in[lane]  = bc_lane_data_out[lane-1];
    end
  end : gen_lanes

  ////////////////////////////////////////////////////////////////////////////
  // Reducer
  ////////////////////////////////////////////////////////////////////////////

  vec_reducer i_reducer (
    .clk_i       (clk_i       ),
    .arst_n_i    (arst_n_i    ),
    .red_start_i (red_start   ),
    .red_op_i    (red_op      ),
    .red_lane_i  (red_lane    ),
    .lane_data_i (lane_rd_data),
    .resp_valid_o(resp_valid_o),
    .resp_data_o (resp_data_o )
  );

endmodule : vec_top

`default_nettype wire

// File: tb/vec_checker.sv
// Bound into vec_top; assumes the host keeps the one-cycle strobe and issues only when idle
`timescale 1ns/1ps
`default_nettype none

module vec_checker (
  input logic             clk_i,
  input logic             arst_n_i,
  input logic             req_valid_i,
  input vec_pkg::opcode_e req_op_i,
  input logic             busy_o,
  input logic             resp_valid_o
);

  // Failed properties so far
  int unsigned fail_cnt = 0;

  // Response is a single-cycle strobe
  resp_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_valid_o |=> !resp_valid_o)
    else begin
      $error("resp_valid_o stayed high for more than one cycle");
      fail_cnt++;
    end

  // Host respects busy_o
  req_not_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_valid_i |-> !busy_o)
    else begin
      $error("req_valid_i arrived while busy_o was high");
      fail_cnt++;
    end

  // Reduce and extract answer exactly two edges after the request
  resp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_valid_i && !busy_o && (req_op_i inside {vec_pkg::OP_VREDSUM, vec_pkg::OP_VEXT}))
      |=> !resp_valid_o ##1 resp_valid_o)
    else begin
      $error("resp_valid_o did not follow the reduce request two edges later");
      fail_cnt++;
    end

  // Idle once reset is released
  idle_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !busy_o)
    else begin
      $error("busy_o was high right after reset");
      fail_cnt++;
    end

endmodule : vec_checker

bind vec_top vec_checker i_checker (.*);

`default_nettype wire

// File: tb/tb_vec_top.sv
// Issues one instruction at a time through busy_o and checks every reduce or extract response
`timescale 1ns/1ps
`default_nettype none

module tb_vec_top;

  localparam int ClkPeriod  = 100;
  localparam int DriveDelay = 10;
  localparam int RandInstr  = 200;
  // reset 40, iota 5, bcast 3, add and xor 12, redsum 8, random
  localparam int NumInstr   = 40 + 5 + 3 + 12 + 8 + RandInstr;
  localparam int TimeoutCyc = NumInstr * 6 + 60;

  logic               clk;
  logic               arst_n;
  logic               req_valid;
  vec_pkg::opcode_e   req_op;
  vec_pkg::vreg_idx_t req_vd, req_vs1, req_vs2;
  vec_pkg::elem_t     req_scalar;
  vec_pkg::lane_idx_t req_lane;
  logic               busy;
  logic               resp_valid;
  vec_pkg::elem_t     resp_data;

  vec_pkg::elem_t     model [vec_pkg::NrLanes][vec_pkg::NrVRegs];
  vec_pkg::elem_t     exp_data_q [$];
  string              exp_name_q [$];
  int                 exp_cyc_q [$];
  int                 cycle_cnt;
  int                 data_errors;
  int                 protocol_errors;
  integer             seed;

  vec_top i_dut (
    .clk_i       (clk       ),
    .arst_n_i    (arst_n    ),
    .req_valid_i (req_valid ),
    .req_op_i    (req_op    ),
    .req_vd_i    (req_vd    ),
    .req_vs1_i   (req_vs1   ),
    .req_vs2_i   (req_vs2   ),
    .req_scalar_i(req_scalar),
    .req_lane_i  (req_lane  ),
    .busy_o      (busy      ),
    .resp_valid_o(resp_valid),
    .resp_data_o (resp_data )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Updates the model and returns the scalar result of reduce and extract
  function automatic vec_pkg::elem_t model_apply(vec_pkg::opcode_e op, vec_pkg::vreg_idx_t vd,
      vec_pkg::vreg_idx_t vs1, vec_pkg::vreg_idx_t vs2, vec_pkg::elem_t scalar,
      vec_pkg::lane_idx_t lane);
    vec_pkg::elem_t res;
    res = '0;
    for (int k = 0; k < vec_pkg::NrLanes; k++) begin
      case (op)
        vec_pkg::OP_VADD:    model[k][vd] = model[k][vs1] + model[k][vs2];
        vec_pkg::OP_VXOR:    model[k][vd] = model[k][vs1] ^ model[k][vs2];
        vec_pkg::OP_VIOTA:   model[k][vd] = scalar + vec_pkg::elem_t'(k);
        vec_pkg::OP_VBCAST:  model[k][vd] = scalar;
        vec_pkg::OP_VREDSUM: res = res + model[k][vs1];
        default:             res = model[lane][vs1];
      endcase
    end
    return res;
  endfunction

  // Cycles of busy_o each opcode should raise
  function automatic int busy_cycles(vec_pkg::opcode_e op);
    if (op == vec_pkg::OP_VBCAST) return vec_pkg::NrLanes;
    if (op inside {vec_pkg::OP_VREDSUM, vec_pkg::OP_VEXT}) return 2;
    return 0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Called just after an edge; returns after the gap that the host must leave
  task automatic issue(input string name, input vec_pkg::opcode_e op,
      input vec_pkg::vreg_idx_t vd, input vec_pkg::vreg_idx_t vs1,
      input vec_pkg::vreg_idx_t vs2, input vec_pkg::elem_t scalar,
      input vec_pkg::lane_idx_t lane);
    vec_pkg::elem_t exp;
    int             busy_n;
    exp    = model_apply(op, vd, vs1, vs2, scalar, lane);
    busy_n = 0;
    while (busy) begin
      @(posedge clk);
      #DriveDelay;
    end
    req_valid  = 1'b1;
    req_op     = op;
    req_vd     = vd;
    req_vs1    = vs1;
    req_vs2    = vs2;
    req_scalar = scalar;
    req_lane   = lane;
    @(posedge clk);
    #DriveDelay;
    req_valid = 1'b0;
    if (op inside {vec_pkg::OP_VREDSUM, vec_pkg::OP_VEXT}) begin
      exp_data_q.push_back(exp);
      exp_name_q.push_back(name);
      exp_cyc_q.push_back(cycle_cnt + 1);
    end
    while (busy) begin
      busy_n++;
      @(posedge clk);
      #DriveDelay;
    end
    if (busy_n == 0) begin
      @(posedge clk);
      #DriveDelay;
    end
    assert (busy_n == busy_cycles(op)) else begin
      protocol_errors++;
      $display("error %s busy cycles: expected %0d actual %0d", name, busy_cycles(op), busy_n);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Response compare
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : compare_resp
    string          name;
    vec_pkg::elem_t exp;
    int             cyc;
    if (arst_n && resp_valid) begin
      if (exp_data_q.size() == 0) begin
        protocol_errors++;
        $display("A response arrived with no reduce or extract waiting at %0t", $time);
      end else begin
        exp  = exp_data_q.pop_front();
        name = exp_name_q.pop_front();
        cyc  = exp_cyc_q.pop_front();
        assert (resp_data == exp) else begin
          data_errors++;
          $display("error %s: expected %h actual %h", name, exp, resp_data);
        end
        assert (cycle_cnt == cyc) else begin
          protocol_errors++;
          $display("error %s timing: expected cycle %0d actual %0d", name, cyc, cycle_cnt);
        end
      end
    end
  end

  initial begin : watchdog
    #(TimeoutCyc * ClkPeriod);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCyc);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin : main
    vec_pkg::elem_t   v;
    vec_pkg::opcode_e op;
    int               assert_errors;
    clk             = 1'b0;
    arst_n          = 1'b0;
    req_valid       = 1'b0;
    req_op          = vec_pkg::OP_VADD;
    req_vd          = '0;
    req_vs1         = '0;
    req_vs2         = '0;
    req_scalar      = '0;
    req_lane        = '0;
    cycle_cnt       = 0;
    data_errors     = 0;
    protocol_errors = 0;
    seed            = 32'h7000f0fa;
    for (int k = 0; k < vec_pkg::NrLanes; k++)
      for (int r = 0; r < vec_pkg::NrVRegs; r++) model[k][r] = '0;
    repeat (4) @(posedge clk);
    #DriveDelay;
    arst_n = 1'b1;

    // Every register is zero out of reset
    for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
      for (int k = 0; k < vec_pkg::NrLanes; k++)
        issue("reset_ext", vec_pkg::OP_VEXT, 0, r, 0, 0, k);
      issue("reset_sum", vec_pkg::OP_VREDSUM, 0, r, 0, 0, 0);
    end

    // Iota then extract of each lane
    issue("iota", vec_pkg::OP_VIOTA, 5, 0, 0, 16'h1230, 0);
    for (int k = 0; k < vec_pkg::NrLanes; k++)
      issue("iota_ext", vec_pkg::OP_VEXT, 0, 5, 0, 0, k);

    // Broadcast down the chain, sum and read of the last lane
    v = $random(seed);
    issue("bcast", vec_pkg::OP_VBCAST, 6, 0, 0, v, 0);
    issue("bcast_sum", vec_pkg::OP_VREDSUM, 0, 6, 0, 0, 0);
    issue("bcast_ext", vec_pkg::OP_VEXT, 0, 6, 0, 0, vec_pkg::NrLanes - 1);

    // Element-wise add and xor
    issue("setup_iota", vec_pkg::OP_VIOTA, 1, 0, 0, $random(seed), 0);
    issue("setup_bcast", vec_pkg::OP_VBCAST, 2, 0, 0, $random(seed), 0);
    issue("vadd", vec_pkg::OP_VADD, 3, 1, 2, 0, 0);
    issue("vxor", vec_pkg::OP_VXOR, 4, 3, 1, 0, 0);
    for (int k = 0; k < vec_pkg::NrLanes; k++) begin
      issue("vadd_ext", vec_pkg::OP_VEXT, 0, 3, 0, 0, k);
      issue("vxor_ext", vec_pkg::OP_VEXT, 0, 4, 0, 0, k);
    end

    // Wrapping sums over random registers
    for (int i = 0; i < 8; i++)
      issue("redsum", vec_pkg::OP_VREDSUM, 0, $random(seed), 0, 0, 0);

    for (int i = 0; i < RandInstr; i++) begin
      op = vec_pkg::opcode_e'($unsigned($random(seed)) % 6);
      issue("random", op, $random(seed), $random(seed), $random(seed), $random(seed),
            $random(seed));
    end

    repeat (4) @(posedge clk);
    assert (exp_data_q.size() == 0) else begin
      protocol_errors += exp_data_q.size();
      $display("%0d expected responses never arrived", exp_data_q.size());
    end
    // Property failures seen by the bound checker
    assert_errors = i_dut.i_checker.fail_cnt;
    $display("Errors: data %0d, protocol %0d, assertion %0d", data_errors, protocol_errors,
             assert_errors);
    if (data_errors + protocol_errors + assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : tb_vec_top

`default_nettype wire

// File: build.f
design/vec_pkg.sv
design/vec_sequencer.sv
design/vec_lane.sv
design/vec_reducer.sv
design/vec_top.sv
tb/vec_checker.sv
tb/tb_vec_top.sv
